// ==== Makefile ====
# Verilator build and run for the memory path testbench

TOP             ?= tb_ceres_mem
BUILD_DIR       ?= build
FILELIST        ?= vlog.f
LOG             ?= $(BUILD_DIR)/sim.log
VERILATOR       ?= verilator
VERILATOR_FLAGS ?= --binary --timing --assert -j 0

# Sources come from the file list, include dirs are skipped
SRCS    := $(filter-out +%,$(shell cat $(FILELIST)))
HDRS    := $(wildcard src/*.svh)
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

# Rebuilt only when a source, header or the file list changes
$(SIM_BIN): $(SRCS) $(HDRS) $(FILELIST)
	$(VERILATOR) $(VERILATOR_FLAGS) -f $(FILELIST) --top-module $(TOP) -Mdir $(BUILD_DIR)

# A crash or the fail message in the log fails the run
run: $(SIM_BIN)
	@$(SIM_BIN) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "TESTBENCH FAILED" $(LOG); then \
	  echo "simulation reported failure, see $(LOG)"; \
	  exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR)

// ==== src/ceres_mem_cfg.svh ====
// Memory path configuration: RAM size, read latency, line width and RAM region
`ifndef CERES_MEM_CFG_SVH
`define CERES_MEM_CFG_SVH

// ==================================================
// RAM geometry
// ==================================================
// Capacity in KiB, 32 KiB gives 8192 words
`define CERES_RAM_SIZE_KB 32

// Cache line width in bits
`define CERES_LINE_W 128

// Read acknowledge delay stages, at least 2
`define CERES_RAM_LATENCY 4

// ==================================================
// Address map
// ==================================================
// Main RAM region
`define CERES_RAM_BASE 32'h8000_0000

// Upper address bits compared for the region
`define CERES_RAM_MASK 32'hF000_0000

`endif

// ==== src/ceres_mem_pkg.sv ====
// Memory path types: Wishbone request/response structs, cycle types, line types
`include "ceres_mem_cfg.svh"

package ceres_mem_pkg;

  // ==================================================
  // Line geometry
  // ==================================================
  localparam int unsigned LINE_BYTES     = `CERES_LINE_W / 8;
  localparam int unsigned WORDS_PER_LINE = `CERES_LINE_W / 32;
  localparam int unsigned BYTE_OFF_W     = $clog2(LINE_BYTES);
  localparam int unsigned WORD_OFF_W     = $clog2(WORDS_PER_LINE);
  localparam int unsigned RAM_LINES      = (`CERES_RAM_SIZE_KB * 1024) / LINE_BYTES;
  localparam int unsigned LINE_ADDR_W    = $clog2(RAM_LINES);

  typedef logic [`CERES_LINE_W-1:0] line_t;
  typedef logic [LINE_BYTES-1:0]    line_strb_t;
  typedef logic [LINE_ADDR_W-1:0]   line_addr_t;

  // ==================================================
  // Wishbone B4
  // ==================================================
  // Cycle type identifier
  typedef enum logic [2:0] {
    WB_CTI_CLASSIC = 3'b000,
    WB_CTI_INCR    = 3'b010,
    WB_CTI_EOB     = 3'b111
  } wb_cti_e;

  // Master to slave
  typedef struct packed {
    logic        cyc;
    logic        stb;
    logic        we;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    wb_cti_e     cti;
  } wb_req_t;

  // Slave to master, no stall line
  typedef struct packed {
    logic [31:0] dat;
    logic        ack;
    logic        err;
  } wb_rsp_t;

endpackage

// ==== src/ceres_mem_top.sv ====
// Main memory path top: address decoder, Wishbone line adapter and line RAM
module ceres_mem_top
  import ceres_mem_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o
);

  // Decoder to adapter
  wb_req_t ram_req;
  wb_rsp_t ram_rsp;

  // Adapter to RAM line port
  line_addr_t ram_addr;
  line_t      ram_wdata;
  line_strb_t ram_wstrb;
  logic       ram_rd_en;
  line_t      ram_rdata;

  // ==================================================
  // Region decode
  // ==================================================
  wb_addr_decode i_decode (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .wb_req_i (wb_req_i),
    .wb_rsp_o (wb_rsp_o),
    .ram_req_o(ram_req),
    .ram_rsp_i(ram_rsp)
  );

  // ==================================================
  // RAM slave
  // ==================================================
  wb_line_ram_adapter i_adapter (
    .clk_i      (clk_i),
    .rst_ni     (rst_ni),
    .wb_req_i   (ram_req),
    .wb_rsp_o   (ram_rsp),
    .ram_addr_o (ram_addr),
    .ram_wdata_o(ram_wdata),
    .ram_wstrb_o(ram_wstrb),
    .ram_rd_en_o(ram_rd_en),
    .ram_rdata_i(ram_rdata)
  );

  line_ram i_ram (
    .clk_i  (clk_i),
    .rst_ni (rst_ni),
    .addr_i (ram_addr),
    .wdata_i(ram_wdata),
    .wstrb_i(ram_wstrb),
    .rd_en_i(ram_rd_en),
    .rdata_o(ram_rdata)
  );

endmodule

// ==== src/line_ram.sv ====
// Line-wide RAM with per-byte write strobes and a registered read port
`include "ceres_mem_cfg.svh"

module line_ram
  import ceres_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  line_addr_t addr_i,
  input  line_t      wdata_i,
  input  line_strb_t wstrb_i,
  input  logic       rd_en_i,
  output line_t      rdata_o
);

  // ==================================================
  // Storage
  // ==================================================
  // One entry per cache line
  line_t mem_q [RAM_LINES];
  line_t rdata_q;

  // Byte-granular write, lands at the clock edge
  always_ff @(posedge clk_i) begin
    for (int b = 0; b < LINE_BYTES; b++) begin
      if (wstrb_i[b]) begin
        mem_q[addr_i][b*8 +: 8] <= wdata_i[b*8 +: 8];
      end
    end
  end

  // Read data one cycle after rd_en_i
  // Output holds its last value otherwise
  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      rdata_q <= mem_q[addr_i];
    end
  end

  assign rdata_o = rdata_q;

  // ==================================================
  // Checks
  // ==================================================
  // Strobes come from the adapter decode, must be clean once out of reset
  a_wstrb_known: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !$isunknown(wstrb_i)
  ) else $error("line_ram: unknown write strobe %h", wstrb_i);

endmodule

// ==== src/wb_addr_decode.sv ====
// Wishbone region decoder, RAM hits go to the adapter and anything else gets err
`include "ceres_mem_cfg.svh"

module wb_addr_decode
  import ceres_mem_pkg::*;
(
  input  logic    clk_i,
  input  logic    rst_ni,
  input  wb_req_t wb_req_i,
  output wb_rsp_t wb_rsp_o,
  output wb_req_t ram_req_o,
  input  wb_rsp_t ram_rsp_i
);

  // Address falls inside the RAM window
  logic ram_hit;

  // ==================================================
  // Region match
  // ==================================================
  assign ram_hit = ((wb_req_i.adr & `CERES_RAM_MASK) == `CERES_RAM_BASE);

  // ==================================================
  // Request toward the RAM adapter
  // ==================================================
  // Everything passes, stb only on a hit
  always_comb begin
    ram_req_o     = wb_req_i;
    ram_req_o.stb = wb_req_i.stb && ram_hit;
  end

  // ==================================================
  // Response toward the master
  // ==================================================
  always_comb begin
    if (ram_hit) begin
      wb_rsp_o = ram_rsp_i;
    end else begin
      // Unmapped, error in the strobe cycle
      wb_rsp_o.dat = '0;
      wb_rsp_o.ack = 1'b0;
      wb_rsp_o.err = wb_req_i.cyc && wb_req_i.stb;
    end
  end

  // ==================================================
  // Checks
  // ==================================================
  // Adapter ack and decoder err stay exclusive at the port
  a_ack_err_excl: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    !(wb_rsp_o.ack && wb_rsp_o.err)
  ) else $error("decode: ack and err together");

  // Err only answers a live strobe
  a_err_with_stb: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_o.err |-> (wb_req_i.cyc && wb_req_i.stb)
  ) else $error("decode: err without strobe");

endmodule

// ==== src/wb_line_ram_adapter.sv ====
// Wishbone slave in front of the line RAM, with read latency pipe and burst line buffer
`include "ceres_mem_cfg.svh"

module wb_line_ram_adapter
  import ceres_mem_pkg::*;
(
  input  logic       clk_i,
  input  logic       rst_ni,
  input  wb_req_t    wb_req_i,
  output wb_rsp_t    wb_rsp_o,
  output line_addr_t ram_addr_o,
  output line_t      ram_wdata_o,
  output line_strb_t ram_wstrb_o,
  output logic       ram_rd_en_o,
  input  line_t      ram_rdata_i
);

  // Depth of the ack delay pipe, needs at least 2
  localparam int unsigned LAT = `CERES_RAM_LATENCY;

  // Request decode
  logic                  req;
  logic                  wr_req;
  logic                  rd_req;
  logic [WORD_OFF_W-1:0] word_off;

  // Latency pipe
  logic           pending_q;
  logic [LAT-1:0] delay_q;

  // Burst line buffer
  line_t buf_q;
  logic  buf_valid_q;
  line_t src_line;

  // Ack sources
  logic pipe_ack;
  logic burst_ack;
  logic ack;

  // ==================================================
  // Request decode
  // ==================================================
  assign req      = wb_req_i.cyc && wb_req_i.stb;
  assign wr_req   = req && wb_req_i.we;
  assign rd_req   = req && !wb_req_i.we;

  // Word within the 16-byte line
  assign word_off = wb_req_i.adr[BYTE_OFF_W-1:2];

  // Byte address to line index
  assign ram_addr_o = wb_req_i.adr[BYTE_OFF_W +: LINE_ADDR_W];

  // ==================================================
  // Write path
  // ==================================================
  // Same word in every slot, strobes pick the real one
  assign ram_wdata_o = {WORDS_PER_LINE{wb_req_i.dat}};

  always_comb begin
    ram_wstrb_o = '0;
    if (wr_req) begin
      ram_wstrb_o[word_off*4 +: 4] = wb_req_i.sel;
    end
  end

  // ==================================================
  // Read latency pipe
  // ==================================================
  // Only go to the RAM when the buffer cannot serve the beat
  assign ram_rd_en_o = rd_req && !buf_valid_q;

  // Pending bit enters the shift chain one cycle after the strobe,
  // so the ack lands LAT+1 cycles after the first strobe cycle
  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      pending_q <= 1'b0;
      delay_q   <= '0;
    end else if (ack) begin
      // Beat done, flush for the next access
      pending_q <= 1'b0;
      delay_q   <= '0;
    end else begin
      pending_q <= ram_rd_en_o;
      delay_q   <= {delay_q[LAT-2:0], pending_q};
    end
  end

  assign pipe_ack = delay_q[LAT-1];

  // ==================================================
  // Burst buffer
  // ==================================================
  // Later burst beats answered straight from the buffer
  assign burst_ack = rd_req && buf_valid_q;

  always_ff @(posedge clk_i) begin
    if (!rst_ni) begin
      buf_valid_q <= 1'b0;
    end else if (!wb_req_i.cyc || wr_req) begin
      // Cycle ended or line may change under us
      buf_valid_q <= 1'b0;
    end else if (burst_ack && (wb_req_i.cti == WB_CTI_EOB)) begin
      buf_valid_q <= 1'b0;
    end else if (pipe_ack && (wb_req_i.cti == WB_CTI_INCR)) begin
      buf_valid_q <= 1'b1;
    end
  end

  // Line capture on the first beat of an incrementing burst
  always_ff @(posedge clk_i) begin
    if (pipe_ack && (wb_req_i.cti == WB_CTI_INCR)) begin
      buf_q <= ram_rdata_i;
    end
  end

  // ==================================================
  // Response
  // ==================================================
  assign src_line = buf_valid_q ? buf_q : ram_rdata_i;

  // Writes ack at once, first read after the pipe, burst beats at once
  assign ack = wr_req || pipe_ack || burst_ack;

  assign wb_rsp_o.dat = src_line[word_off*32 +: 32];
  assign wb_rsp_o.ack = ack;
  assign wb_rsp_o.err = 1'b0;

  // ==================================================
  // Checks
  // ==================================================
  // Delayed ack must still find the master holding its request
  a_ack_in_cycle: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    wb_rsp_o.ack |-> (wb_req_i.cyc && wb_req_i.stb)
  ) else $error("adapter: ack without cyc and stb");

  // No write reaches the RAM while a read is still in flight
  a_no_wr_rd: assert property (
    @(posedge clk_i) disable iff (!rst_ni)
    (|ram_wstrb_o) |-> !(pending_q || (|delay_q))
  ) else $error("adapter: write strobe while a read is in flight");

endmodule

// ==== verif/tb_ceres_mem.sv ====
// Memory path testbench: a table of Wishbone accesses checked against a shadow word memory
`include "ceres_mem_cfg.svh"

module tb_ceres_mem
  import ceres_mem_pkg::*;
();

  // ==================================================
  // Timing and sizes
  // ==================================================
  localparam int CLK_PERIOD = 100;
  localparam int DRIVE_DLY  = 10;
  localparam int RST_CYCLES = 5;
  localparam int LAT        = `CERES_RAM_LATENCY;
  // Single read ack lands this many cycles after the first strobe cycle
  localparam int RD_CYCLES  = LAT + 1;
  localparam int ACK_LIMIT  = LAT + 8;
  localparam int RAM_WORDS  = `CERES_RAM_SIZE_KB * 256;
  localparam int N_TESTS    = 18;
  localparam int WATCHDOG_CYCLES = N_TESTS * (LAT + 8) * 4 + RST_CYCLES;

  // Kinds of table entries
  typedef enum logic [2:0] {K_WR, K_RD, K_BURST, K_BAD_WR, K_BAD_RD} kind_e;

  typedef struct packed {
    kind_e       kind;
    logic [31:0] adr;
    logic [31:0] dat;
    logic [3:0]  sel;
    logic [2:0]  blen;
  } test_t;

  logic    clk;
  logic    rst_n;
  wb_req_t wb_req;
  wb_rsp_t wb_rsp;

  test_t       tbl [N_TESTS];
  int          n_built;
  logic [31:0] rng_state;
  // Expected RAM contents, one entry per 32-bit word
  logic [31:0] shadow [RAM_WORDS];
  int          err_cnt;
  int          chk_cnt;
  int          fail_cnt;
  bit          test_bad;

  ceres_mem_top DUT (
    .clk_i   (clk),
    .rst_ni  (rst_n),
    .wb_req_i(wb_req),
    .wb_rsp_o(wb_rsp)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  // ==================================================
  // Stimulus table
  // ==================================================
  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    logic [31:0] y;
    y = x ^ (x << 13);
    y = y ^ (y >> 17);
    y = y ^ (y << 5);
    return y;
  endfunction

  // Random entries take their data from the generator
  task automatic add_entry(input kind_e kind, input logic [31:0] adr, input logic [31:0] dat,
                           input logic [3:0] sel, input logic [2:0] blen, input bit rnd);
    test_t e;
    e.kind = kind;
    e.adr  = adr;
    e.dat  = dat;
    e.sel  = sel;
    e.blen = blen;
    if (rnd) begin
      rng_state = xorshift32(rng_state);
      e.dat     = rng_state;
    end
    tbl[n_built] = e;
    n_built++;
  endtask

  task automatic build_table();
    // Full write then read back
    add_entry(K_WR,     32'h8000_0000, 32'h0,         4'hF, 3'd1, 1'b1);
    add_entry(K_RD,     32'h8000_0000, 32'h0,         4'hF, 3'd1, 1'b0);
    // Fill the rest of line 0
    add_entry(K_WR,     32'h8000_0004, 32'h0,         4'hF, 3'd1, 1'b1);
    add_entry(K_WR,     32'h8000_0008, 32'h0,         4'hF, 3'd1, 1'b1);
    add_entry(K_WR,     32'h8000_000C, 32'h0,         4'hF, 3'd1, 1'b1);
    // Byte lanes 0 and 2 only
    add_entry(K_WR,     32'h8000_0008, 32'hA5A5_5A5A, 4'h5, 3'd1, 1'b0);
    add_entry(K_RD,     32'h8000_0008, 32'h0,         4'hF, 3'd1, 1'b0);
    // Neighbours of the partial write
    add_entry(K_RD,     32'h8000_0004, 32'h0,         4'hF, 3'd1, 1'b0);
    add_entry(K_RD,     32'h8000_000C, 32'h0,         4'hF, 3'd1, 1'b0);
    add_entry(K_BURST,  32'h8000_0000, 32'h0,         4'hF, 3'd4, 1'b0);
    // Buffer must be gone after end of burst
    add_entry(K_RD,     32'h8000_0000, 32'h0,         4'hF, 3'd1, 1'b0);
    add_entry(K_WR,     32'h8000_0100, 32'h1234_5678, 4'hF, 3'd1, 1'b0);
    // Same line index as 0x8000_0100 but outside the region
    add_entry(K_BAD_WR, 32'h1000_0100, 32'hDEAD_BEEF, 4'hF, 3'd1, 1'b0);
    add_entry(K_BAD_RD, 32'h4000_0000, 32'h0,         4'hF, 3'd1, 1'b0);
    add_entry(K_RD,     32'h8000_0100, 32'h0,         4'hF, 3'd1, 1'b0);
    // Last line of the RAM
    add_entry(K_WR,     32'h8000_7FF8, 32'h0,         4'hF, 3'd1, 1'b1);
    add_entry(K_WR,     32'h8000_7FF8, 32'h0,         4'h2, 3'd1, 1'b1);
    add_entry(K_RD,     32'h8000_7FF8, 32'h0,         4'hF, 3'd1, 1'b0);
  endtask

  // ==================================================
  // Shadow model and checks
  // ==================================================
  function automatic int word_index(input logic [31:0] adr);
    return int'((adr >> 2) & 32'(RAM_WORDS - 1));
  endfunction

  task automatic shadow_write(input logic [31:0] adr, input logic [31:0] dat,
                              input logic [3:0] sel);
    int idx;
    idx = word_index(adr);
    for (int b = 0; b < 4; b++) begin
      if (sel[b]) begin
        shadow[idx][b*8 +: 8] = dat[b*8 +: 8];
      end
    end
  endtask

  // Data compared only where the bus defines it
  task automatic check_rsp(input string what, input wb_rsp_t exp, input wb_rsp_t act,
                           input bit cmp_dat);
    chk_cnt++;
    if (act.ack !== exp.ack) begin
      $display("CHECK FAILED wb_rsp_o.ack (%s) exp %h got %h", what, exp.ack, act.ack);
      err_cnt++;
      test_bad = 1'b1;
    end
    if (act.err !== exp.err) begin
      $display("CHECK FAILED wb_rsp_o.err (%s) exp %h got %h", what, exp.err, act.err);
      err_cnt++;
      test_bad = 1'b1;
    end
    if (cmp_dat && (act.dat !== exp.dat)) begin
      $display("CHECK FAILED wb_rsp_o.dat (%s) exp %h got %h", what, exp.dat, act.dat);
      err_cnt++;
      test_bad = 1'b1;
    end
  endtask

  task automatic check_latency(input string what, input int exp, input int act);
    chk_cnt++;
    if (act != exp) begin
      $display("CHECK FAILED ack_latency (%s) exp %h got %h", what, exp, act);
      err_cnt++;
      test_bad = 1'b1;
    end
  endtask

  // ==================================================
  // Bus driver
  // ==================================================
  function automatic wb_req_t make_req(input bit we, input logic [31:0] adr,
                                       input logic [31:0] dat, input logic [3:0] sel,
                                       input wb_cti_e cti);
    wb_req_t r;
    r.cyc = 1'b1;
    r.stb = 1'b1;
    r.we  = we;
    r.adr = adr;
    r.dat = dat;
    r.sel = sel;
    r.cti = cti;
    return r;
  endfunction

  // Inputs change a little after the rising edge
  task automatic wait_slot();
    @(posedge clk);
    #DRIVE_DLY;
  endtask

  // Hold the beat, sample mid-cycle until ack or err
  task automatic run_beat(input wb_req_t req, output wb_rsp_t rsp, output int lat,
                          output bit got);
    wb_req = req;
    lat    = 0;
    got    = 1'b0;
    rsp    = '0;
    while (!got && (lat <= ACK_LIMIT)) begin
      @(negedge clk);
      rsp = wb_rsp;
      if (rsp.ack || rsp.err) begin
        got = 1'b1;
      end else begin
        lat++;
      end
    end
  endtask

  task automatic access(input string what, input wb_req_t req, input wb_rsp_t exp,
                        input bit cmp_dat, input int exp_lat);
    wb_rsp_t rsp;
    int      lat;
    bit      got;
    wait_slot();
    run_beat(req, rsp, lat, got);
    if (!got) begin
      $display("%s: neither ack nor err came within %0d cycles", what, ACK_LIMIT);
      err_cnt++;
      test_bad = 1'b1;
    end else begin
      check_rsp(what, exp, rsp, cmp_dat);
      check_latency(what, exp_lat, lat);
    end
  endtask

  task automatic go_idle();
    wait_slot();
    wb_req = '0;
  endtask

  function automatic string kind_name(input kind_e k);
    case (k)
      K_WR:     return "write";
      K_RD:     return "read";
      K_BURST:  return "burst";
      K_BAD_WR: return "unmapped write";
      default:  return "unmapped read";
    endcase
  endfunction

  // ==================================================
  // Test sequencing
  // ==================================================
  task automatic run_test(input int t);
    test_t   e;
    wb_req_t req;
    wb_rsp_t exp;
    wb_cti_e cti;
    e        = tbl[t];
    test_bad = 1'b0;
    exp      = '0;
    case (e.kind)
      K_WR: begin
        req     = make_req(1'b1, e.adr, e.dat, e.sel, WB_CTI_CLASSIC);
        exp.ack = 1'b1;
        access($sformatf("write %h", e.adr), req, exp, 1'b0, 0);
        shadow_write(e.adr, e.dat, e.sel);
      end
      K_RD: begin
        req     = make_req(1'b0, e.adr, 32'h0, 4'hF, WB_CTI_CLASSIC);
        exp.ack = 1'b1;
        exp.dat = shadow[word_index(e.adr)];
        access($sformatf("read %h", e.adr), req, exp, 1'b1, RD_CYCLES);
      end
      K_BURST: begin
        // Only the first beat pays the RAM latency
        for (int i = 0; i < int'(e.blen); i++) begin
          cti     = (i == int'(e.blen) - 1) ? WB_CTI_EOB : WB_CTI_INCR;
          req     = make_req(1'b0, e.adr + 32'(4 * i), 32'h0, 4'hF, cti);
          exp.ack = 1'b1;
          exp.dat = shadow[word_index(req.adr)];
          access($sformatf("burst beat %0d", i), req, exp, 1'b1, (i == 0) ? RD_CYCLES : 0);
        end
      end
      default: begin
        // Decoder answers at once with zero data
        req     = make_req(e.kind == K_BAD_WR, e.adr, e.dat, e.sel, WB_CTI_CLASSIC);
        exp.err = 1'b1;
        access($sformatf("unmapped %h", e.adr), req, exp, 1'b1, 0);
      end
    endcase
    go_idle();
    if (test_bad) begin
      fail_cnt++;
    end
    $display("test %0d %s at %h: %s", t, kind_name(e.kind), e.adr, test_bad ? "bad" : "ok");
  endtask

  initial begin
    wb_req    = '0;
    rst_n     = 1'b0;
    rng_state = 32'd29;
    n_built   = 0;
    err_cnt   = 0;
    chk_cnt   = 0;
    fail_cnt  = 0;
    test_bad  = 1'b0;
    build_table();
    repeat (RST_CYCLES) @(posedge clk);
    #DRIVE_DLY;
    rst_n = 1'b1;
    for (int t = 0; t < n_built; t++) begin
      run_test(t);
    end
    $display("tests %0d, bad %0d, checks %0d, errors %0d", n_built, fail_cnt, chk_cnt, err_cnt);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

  // Budget covers every entry at worst-case beat count plus reset
  initial begin
    #(CLK_PERIOD * WATCHDOG_CYCLES);
    $display("watchdog expired after %0d cycles, run stopped", WATCHDOG_CYCLES);
    $display("TESTBENCH FAILED");
    $finish;
  end

endmodule

// ==== vlog.f ====
+incdir+src
src/ceres_mem_pkg.sv
src/line_ram.sv
src/wb_line_ram_adapter.sv
src/wb_addr_decode.sv
src/ceres_mem_top.sv
verif/tb_ceres_mem.sv
